/* build.f */
+incdir+.
astro_pkg.sv
game_config.sv
key_decoder.sv
switch_matrix.sv
audio_mixer.sv
astrocade_io.sv
tb_astrocade_io.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the Astrocade I/O testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -f build.f --top-module tb_astrocade_io \
	-Mdir obj_dir -o sim_astrocade_io
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/sim_astrocade_io)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Done: no errors" <<< "$output"; then
	exit 0
else
	echo "Simulation reported failure"
	exit 1
fi

/* tb_astrocade_io.sv */
//==========================================================================
// Astrocade game-side I/O testbench
// Host loads, keyboard and joystick scans and audio mix against a reference
//==========================================================================
`default_nettype none
`include "astro_defines.svh"

module tb_astrocade_io;

	localparam int N_ROW    = 60;
	localparam int N_AUD    = 40;
	localparam int N_LOADS  = 25;
	localparam int N_OPS    = N_LOADS + 16 + 4 * N_ROW + 5 * N_AUD;
	localparam int ACK_WAIT = 8;

	logic                          clk_sys;
	logic                          reset;
	logic                          load_req;
	logic [7:0]                    load_index;
	logic [`ASTRO_LOAD_ADDR_W-1:0] load_addr;
	logic [7:0]                    load_data;
	wire                           load_ack;
	astro_pkg::game_t              game;
	logic [`ASTRO_KEY_W-1:0]       ps2_key;
	logic [`ASTRO_JOY_W-1:0]       joystick_0;
	logic [`ASTRO_JOY_W-1:0]       joystick_1;
	logic                          speech_busy;
	logic [7:0]                    col_select;
	wire  [7:0]                    row_data;
	logic [7:0]                    sound_l;
	logic [7:0]                    sound_r;
	logic [15:0]                   sample_l;
	logic [15:0]                   sample_r;
	wire  [15:0]                   audio_l;
	wire  [15:0]                   audio_r;

	// Model of the DUT state
	astro_pkg::game_t cur_game;
	logic [7:0]       dip_model [`ASTRO_DIP_BYTES];
	logic [5:0]       kb_p1;
	logic [5:0]       kb_p2;
	// Index 0 for function keys and index 1 for panel keys
	logic [1:0]       kb_s1;
	logic [1:0]       kb_s2;
	logic [1:0]       kb_coin;
	logic             ps2_toggle;

	// Checker requests that live for one cycle
	logic             chk_row;
	logic             chk_game;
	logic             chk_audio;
	logic             chk_idle;
	logic [7:0]       exp_row;
	astro_pkg::game_t exp_game;
	logic [15:0]      exp_audio_l;
	logic [15:0]      exp_audio_r;
	int               check_errors;
	int               proto_errors;

	astrocade_io astrocade_io_inst (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.load_req    (load_req),
		.load_index  (load_index),
		.load_addr   (load_addr),
		.load_data   (load_data),
		.load_ack    (load_ack),
		.game        (game),
		.ps2_key     (ps2_key),
		.joystick_0  (joystick_0),
		.joystick_1  (joystick_1),
		.speech_busy (speech_busy),
		.col_select  (col_select),
		.row_data    (row_data),
		.sound_l     (sound_l),
		.sound_r     (sound_r),
		.sample_l    (sample_l),
		.sample_r    (sample_r),
		.audio_l     (audio_l),
		.audio_r     (audio_r)
	);

	initial clk_sys = 1'b0;
	always #2 clk_sys = ~clk_sys;

	//======================================================================
	// Reference model
	//======================================================================

	function automatic astro_pkg::game_t game_from_byte(input logic [7:0] b);
		case (b)
			8'd3:    game_from_byte = astro_pkg::GAME_SPACEZAP;
			8'd4:    game_from_byte = astro_pkg::GAME_GORF;
			8'd5:    game_from_byte = astro_pkg::GAME_WOW;
			8'd6:    game_from_byte = astro_pkg::GAME_ROBBY;
			default: game_from_byte = astro_pkg::GAME_NONE;
		endcase
	endfunction

	// Row byte per game table with p bits R L D U F1 F2
	function automatic logic [7:0] row_ref(input astro_pkg::game_t g,
			input logic [7:0] dip2, input logic [7:0] dip3,
			input logic [5:0] p1, input logic [5:0] p2,
			input logic s1, input logic s2, input logic coin,
			input logic speech, input logic [7:0] col);
		logic [7:0] r;
		r = 8'hFF;
		case (g)
			astro_pkg::GAME_SPACEZAP: begin
				if (col == `ASTRO_COL0) r = {2'b11, ~s2, ~s1, dip2[1], 1'b1, ~coin, 1'b1};
				if (col == `ASTRO_COL1) r = {3'b111, ~p2[4], ~p2[0], ~p2[1], ~p2[2], ~p2[3]};
				if (col == `ASTRO_COL2) r = {2'b11, dip2[0], ~p1[4], ~p1[0], ~p1[1], ~p1[2], ~p1[3]};
			end
			astro_pkg::GAME_GORF: begin
				if (col == `ASTRO_COL0) r = {dip2[2], dip2[0], ~s2, ~s1, 1'b1, dip2[1], ~coin, 1'b1};
				if (col == `ASTRO_COL1) r = {3'b001, ~p2[4], ~p2[0], ~p2[1], ~p2[2], ~p2[3]};
				if (col == `ASTRO_COL2) r = {speech, 2'b01, ~p1[4], ~p1[0], ~p1[1], ~p1[2], ~p1[3]};
			end
			astro_pkg::GAME_ROBBY: begin
				if (col == `ASTRO_COL0) r = {1'b0, ~s2, ~s1, 1'b1, dip2[1], 1'b1, ~coin, 1'b1};
				if (col == `ASTRO_COL1) r = {2'b11, ~p2[4], 1'b1, ~p2[0], ~p2[1], ~p2[2], ~p2[3]};
				if (col == `ASTRO_COL2) r = {2'b11, ~p1[4], 1'b1, ~p1[0], ~p1[1], ~p1[2], ~p1[3]};
			end
			astro_pkg::GAME_WOW: begin
				if (col == `ASTRO_COL0) r = {dip2[2], ~s2, ~s1, 1'b1, dip2[1], 1'b1, ~coin, 1'b1};
				// Fire 2 not inverted on this game
				if (col == `ASTRO_COL1) r = {2'b11, ~p2[4], p2[5], ~p2[0], ~p2[1], ~p2[2], ~p2[3]};
				if (col == `ASTRO_COL2) r = {speech, 1'b1, ~p1[4], p1[5], ~p1[0], ~p1[1], ~p1[2], ~p1[3]};
			end
			default: r = 8'hFF;
		endcase
		// Column 3 is the DIP bank whatever the game
		if (col == `ASTRO_COL3) r = dip3;
		row_ref = r;
	endfunction

	// Left in the upper half and right in the lower half
	function automatic logic [31:0] audio_ref(input astro_pkg::game_t g,
			input logic [7:0] sl, input logic [7:0] sr,
			input logic [15:0] pl, input logic [15:0] pr);
		logic [15:0] l;
		logic [15:0] r;
		case (g)
			astro_pkg::GAME_GORF: begin
				l = {1'b0, sl, sl[7:1]} + {2'b00, pl[15:2]};
				r = {1'b0, sr, sr[7:1]} + {2'b00, pr[15:2]};
			end
			astro_pkg::GAME_WOW, astro_pkg::GAME_ROBBY: begin
				l = {sl, sl};
				r = {sr, sr};
			end
			default: begin
				l = {sl, sl};
				r = {sl, sl};
			end
		endcase
		audio_ref = {l, r};
	endfunction

	// Keyboard merged with sticks
	// Start and coin from stick 0 only
	function automatic logic [7:0] expected_row();
		logic [5:0] p1;
		logic [5:0] p2;
		p1 = kb_p1 | joystick_0[5:0];
		p2 = kb_p2 | joystick_1[5:0];
		expected_row = row_ref(cur_game, dip_model[2], dip_model[3], p1, p2,
			(|kb_s1) | joystick_0[6], (|kb_s2) | joystick_0[7],
			(|kb_coin) | joystick_0[8], speech_busy, col_select);
	endfunction

	//======================================================================
	// Checker
	//======================================================================

	always @(negedge clk_sys) begin
		if (chk_row) begin
			if (row_data !== exp_row) begin
				check_errors++;
				$display("FAILED at %0t: row_data %h, expected %h (game %s, col %h)",
					$time, row_data, exp_row, cur_game.name(), col_select);
			end
		end
		if (chk_game) begin
			if (game !== exp_game) begin
				check_errors++;
				$display("FAILED at %0t: game %s, expected %s",
					$time, game.name(), exp_game.name());
			end
		end
		if (chk_audio) begin
			if (audio_l !== exp_audio_l || audio_r !== exp_audio_r) begin
				check_errors++;
				$display("FAILED at %0t: audio %h/%h, expected %h/%h (game %s)", $time,
					audio_l, audio_r, exp_audio_l, exp_audio_r, cur_game.name());
			end
		end
		if (chk_idle) begin
			if (load_ack !== 1'b0 || audio_l !== 16'd0 || audio_r !== 16'd0) begin
				check_errors++;
				$display("FAILED at %0t: after reset ack %b audio %h/%h, expected all zero",
					$time, load_ack, audio_l, audio_r);
			end
		end
	end

	//======================================================================
	// Stimulus helpers
	//======================================================================

	// Inputs change just after the rising edge
	task automatic step();
		@(posedge clk_sys);
		#1;
		chk_row   = 1'b0;
		chk_game  = 1'b0;
		chk_audio = 1'b0;
		chk_idle  = 1'b0;
	endtask

	task automatic apply_key(input logic [8:0] code, input logic pressed);
		case (code[7:0])
			// Cursor keys ignore the extended bit
			8'h75: kb_p1[3] = pressed;
			8'h72: kb_p1[2] = pressed;
			8'h6B: kb_p1[1] = pressed;
			8'h74: kb_p1[0] = pressed;
			default: begin
				if (!code[8]) begin
					case (code[7:0])
						8'h14: kb_p1[4] = pressed;
						8'h29: kb_p1[5] = pressed;
						8'h05: kb_s1[0] = pressed;
						8'h06: kb_s2[0] = pressed;
						8'h04: kb_coin[0] = pressed;
						8'h16: kb_s1[1] = pressed;
						8'h1E: kb_s2[1] = pressed;
						8'h2E: kb_coin[1] = pressed;
						8'h2D: kb_p2[3] = pressed;
						8'h2B: kb_p2[2] = pressed;
						8'h23: kb_p2[1] = pressed;
						8'h34: kb_p2[0] = pressed;
						8'h1C: kb_p2[4] = pressed;
						8'h1B: kb_p2[5] = pressed;
						default: ;
					endcase
				end
			end
		endcase
	endtask

	task automatic key_event(input logic [8:0] code, input logic pressed);
		ps2_toggle = ~ps2_toggle;
		ps2_key    = {ps2_toggle, pressed, code};
		apply_key(code, pressed);
	endtask

	// Mapped codes with cursor keys at 0 to 3 and two unmapped codes at the end
	function automatic logic [7:0] key_code_at(input int i);
		case (i)
			0:       key_code_at = 8'h75;
			1:       key_code_at = 8'h72;
			2:       key_code_at = 8'h6B;
			3:       key_code_at = 8'h74;
			4:       key_code_at = 8'h14;
			5:       key_code_at = 8'h29;
			6:       key_code_at = 8'h05;
			7:       key_code_at = 8'h06;
			8:       key_code_at = 8'h04;
			9:       key_code_at = 8'h16;
			10:      key_code_at = 8'h1E;
			11:      key_code_at = 8'h2E;
			12:      key_code_at = 8'h2D;
			13:      key_code_at = 8'h2B;
			14:      key_code_at = 8'h23;
			15:      key_code_at = 8'h34;
			16:      key_code_at = 8'h1C;
			17:      key_code_at = 8'h1B;
			18:      key_code_at = 8'h15;
			default: key_code_at = 8'hAA;
		endcase
	endfunction

	// Valid strobes first and then codes that must read FF
	function automatic logic [7:0] col_code_at(input int i);
		case (i)
			0: col_code_at = `ASTRO_COL0;
			1: col_code_at = `ASTRO_COL1;
			2: col_code_at = `ASTRO_COL2;
			3: col_code_at = `ASTRO_COL3;
			4: col_code_at = 8'h00;
			5: col_code_at = 8'h03;
			6: col_code_at = 8'h10;
			7: col_code_at = 8'h80;
			default: col_code_at = 8'hFF;
		endcase
	endfunction

	// Four-phase write with the game checked two cycles after ack
	task automatic host_write(input logic [7:0] idx, input logic [15:0] addr,
			input logic [7:0] data);
		int waited;
		step();
		load_index = idx;
		load_addr  = addr;
		load_data  = data;
		step();
		load_req = 1'b1;
		step();
		waited = 1;
		while (!load_ack && waited < ACK_WAIT) begin
			step();
			waited++;
		end
		if (!load_ack) begin
			proto_errors++;
			$display("Load ack did not rise within %0d cycles at %0t", ACK_WAIT, $time);
		end
		if (idx == `ASTRO_LOAD_GAME) cur_game = game_from_byte(data);
		if (idx == `ASTRO_LOAD_DIP && addr < 16'd8) dip_model[addr[2:0]] = data;
		step();
		load_req = 1'b0;
		step();
		if (idx == `ASTRO_LOAD_GAME) begin
			exp_game = cur_game;
			chk_game = 1'b1;
		end
		waited = 0;
		while (load_ack && waited < ACK_WAIT) begin
			step();
			waited++;
		end
		if (load_ack) begin
			proto_errors++;
			$display("Load ack did not fall within %0d cycles at %0t", ACK_WAIT, $time);
		end
	endtask

	task automatic check_columns();
		for (int c = 0; c < 4; c++) begin
			col_select = col_code_at(c);
			exp_row    = expected_row();
			chk_row    = 1'b1;
			step();
		end
	endtask

	//======================================================================
	// Test sequence
	//======================================================================

	initial begin
		int          seed;
		int          idx;
		logic [31:0] r;
		logic [7:0]  gbyte;
		seed = $urandom(32'h244f);
		reset = 1'b1;
		load_req = 1'b0;
		load_index = 8'd0;
		load_addr = '0;
		load_data = 8'd0;
		ps2_key = '0;
		joystick_0 = '0;
		joystick_1 = '0;
		speech_busy = 1'b0;
		col_select = 8'd0;
		sound_l = 8'd0;
		sound_r = 8'd0;
		sample_l = 16'd0;
		sample_r = 16'd0;
		cur_game = astro_pkg::GAME_NONE;
		for (int i = 0; i < `ASTRO_DIP_BYTES; i++) dip_model[i] = 8'd0;
		kb_p1 = '0;
		kb_p2 = '0;
		kb_s1 = '0;
		kb_s2 = '0;
		kb_coin = '0;
		ps2_toggle = 1'b0;
		chk_row = 1'b0;
		chk_game = 1'b0;
		chk_audio = 1'b0;
		chk_idle = 1'b0;
		exp_row = 8'd0;
		exp_game = astro_pkg::GAME_NONE;
		exp_audio_l = 16'd0;
		exp_audio_r = 16'd0;
		check_errors = 0;
		proto_errors = 0;
		repeat (8) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		// Idle state after reset with no game selected
		for (int c = 0; c < 6; c++) begin
			col_select = col_code_at(c);
			exp_row = expected_row();
			exp_game = astro_pkg::GAME_NONE;
			chk_row = 1'b1;
			chk_game = 1'b1;
			chk_idle = 1'b1;
			step();
		end

		// Game loads where 9 and FF are unknown bytes
		host_write(`ASTRO_LOAD_GAME, 16'h0000, 8'd3);
		host_write(`ASTRO_LOAD_GAME, 16'h1234, 8'd4);
		host_write(`ASTRO_LOAD_GAME, 16'h0001, 8'd5);
		host_write(`ASTRO_LOAD_GAME, 16'hFFFF, 8'd6);
		host_write(`ASTRO_LOAD_GAME, 16'h0000, 8'd9);
		host_write(`ASTRO_LOAD_GAME, 16'h0000, 8'd3);
		host_write(`ASTRO_LOAD_GAME, 16'h0000, 8'hFF);

		// DIP bank writes followed by writes that must be dropped
		host_write(`ASTRO_LOAD_GAME, 16'h0000, 8'd3);
		r = $urandom;
		host_write(`ASTRO_LOAD_DIP, 16'd2, r[7:0]);
		host_write(`ASTRO_LOAD_DIP, 16'd3, r[15:8]);
		host_write(`ASTRO_LOAD_DIP, 16'd0, r[23:16]);
		host_write(`ASTRO_LOAD_DIP, 16'd10, ~r[7:0]);
		host_write(`ASTRO_LOAD_DIP, 16'h0102, ~r[7:0]);
		host_write(8'd7, 16'd3, ~r[15:8]);
		host_write(8'd0, 16'd2, ~r[7:0]);
		check_columns();
		host_write(`ASTRO_LOAD_GAME, 16'h0000, 8'd4);
		check_columns();

		// Random switch scans in each game
		for (int g = 0; g < 4; g++) begin
			gbyte = 8'd3 + 8'(g);
			r = $urandom;
			host_write(`ASTRO_LOAD_GAME, r[15:0], gbyte);
			for (int n = 0; n < N_ROW; n++) begin
				idx = $urandom % 20;
				r = $urandom;
				key_event({(idx < 4) ? r[0] : 1'b0, key_code_at(idx)}, r[1]);
				// Sparse stick bits so keys still show
				joystick_0 = r[10:2] & r[29:21];
				joystick_1 = r[19:11] & r[28:20];
				speech_busy = r[20];
				col_select = col_code_at($urandom % 9);
				step();
				step();
				exp_row = expected_row();
				chk_row = 1'b1;
				step();
			end
		end

		// Audio mix in every game with one cycle latency
		for (int g = 0; g < 5; g++) begin
			gbyte = (g == 0) ? 8'd0 : 8'd2 + 8'(g);
			host_write(`ASTRO_LOAD_GAME, 16'h0000, gbyte);
			for (int n = 0; n < N_AUD; n++) begin
				r = $urandom;
				sound_l = r[7:0];
				sound_r = r[15:8];
				r = $urandom;
				sample_l = r[15:0];
				sample_r = r[31:16];
				step();
				{exp_audio_l, exp_audio_r} = audio_ref(cur_game, sound_l, sound_r,
					sample_l, sample_r);
				chk_audio = 1'b1;
				step();
			end
		end

		step();
		$display("Errors: %0d value mismatches, %0d protocol failures",
			check_errors, proto_errors);
		if (check_errors == 0 && proto_errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	// Watchdog allows 40 cycles per test operation
	initial begin
		repeat (N_OPS * 40) @(posedge clk_sys);
		$display("Watchdog expired after %0d cycles, the test did not finish", N_OPS * 40);
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* astrocade_io.sv */
//==========================================================================
// Astrocade game-side I/O
// Host config load, keyboard and joystick switch matrix, audio mixing
//==========================================================================
`default_nettype none
`include "astro_defines.svh"

module astrocade_io (
	input  wire                           clk_sys,
	input  wire                           reset,
	// Host loader
	input  wire                           load_req,
	input  wire  [7:0]                    load_index,
	input  wire  [`ASTRO_LOAD_ADDR_W-1:0] load_addr,
	input  wire  [7:0]                    load_data,
	output wire                           load_ack,
	// Selected game, to the core
	output astro_pkg::game_t              game,
	// Player inputs
	input  wire  [`ASTRO_KEY_W-1:0]       ps2_key,
	input  wire  [`ASTRO_JOY_W-1:0]       joystick_0,
	input  wire  [`ASTRO_JOY_W-1:0]       joystick_1,
	// Core switch scan
	input  wire                           speech_busy,
	input  wire  [7:0]                    col_select,
	output wire  [7:0]                    row_data,
	// Sound
	input  wire  [7:0]                    sound_l,
	input  wire  [7:0]                    sound_r,
	input  wire  [15:0]                   sample_l,
	input  wire  [15:0]                   sample_r,
	output wire  [15:0]                   audio_l,
	output wire  [15:0]                   audio_r
);

	wire [7:0]  dip2;
	wire [7:0]  dip3;
	wire [17:0] keys;

	// DIP bank 0 serves no supported game
	game_config game_config_inst (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.load_req   (load_req),
		.load_index (load_index),
		.load_addr  (load_addr),
		.load_data  (load_data),
		.load_ack   (load_ack),
		.game       (game),
		.dip0       (),
		.dip2       (dip2),
		.dip3       (dip3)
	);

	key_decoder key_decoder_inst (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ps2_key (ps2_key),
		.keys    (keys)
	);

	switch_matrix switch_matrix_inst (
		.game        (game),
		.dip2        (dip2),
		.dip3        (dip3),
		.keys        (keys),
		.joystick_0  (joystick_0),
		.joystick_1  (joystick_1),
		.speech_busy (speech_busy),
		.col_select  (col_select),
		.row_data    (row_data)
	);

	audio_mixer audio_mixer_inst (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.game     (game),
		.sound_l  (sound_l),
		.sound_r  (sound_r),
		.sample_l (sample_l),
		.sample_r (sample_r),
		.audio_l  (audio_l),
		.audio_r  (audio_r)
	);

endmodule

`default_nettype wire

/* audio_mixer.sv */
//==========================================================================
// Audio mixer
// Per-game mix of sound chip output and speech samples to 16-bit channels
//==========================================================================
`default_nettype none
`include "astro_defines.svh"

module audio_mixer (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  wire  astro_pkg::game_t game,
	input  wire  [7:0]             sound_l,
	input  wire  [7:0]             sound_r,
	input  wire  [15:0]            sample_l,
	input  wire  [15:0]            sample_r,
	output logic [15:0]            audio_l,
	output logic [15:0]            audio_r
);

	// Chip byte halved plus speech quartered, wraps at 16 bits
	// Speech is much louder than the chip, so it gets the bigger cut
	function automatic logic [15:0] speech_mix(input logic [7:0] snd,
			input logic [15:0] samp);
		speech_mix = ({snd, snd} >> `ASTRO_SOUND_SHIFT) + (samp >> `ASTRO_SPEECH_SHIFT);
	endfunction

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			audio_l <= 16'd0;
			audio_r <= 16'd0;
		end else begin
			case (game)
				// Sound chip plus speech
				astro_pkg::GAME_GORF: begin
					audio_l <= speech_mix(sound_l, sample_l);
					audio_r <= speech_mix(sound_r, sample_r);
				end
				// Two sound chips
				astro_pkg::GAME_WOW,
				astro_pkg::GAME_ROBBY: begin
					audio_l <= {sound_l, sound_l};
					audio_r <= {sound_r, sound_r};
				end
				// Single chip, mono
				default: begin
					audio_l <= {sound_l, sound_l};
					audio_r <= {sound_l, sound_l};
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* switch_matrix.sv */
//==========================================================================
// Switch matrix
// Answers the core's column scans with per-game active-low row bytes
//==========================================================================
`default_nettype none
`include "astro_defines.svh"

module switch_matrix (
	input  wire  astro_pkg::game_t   game,
	input  wire  [7:0]               dip2,
	input  wire  [7:0]               dip3,
	input  wire  [17:0]              keys,
	input  wire  [`ASTRO_JOY_W-1:0]  joystick_0,
	input  wire  [`ASTRO_JOY_W-1:0]  joystick_1,
	input  wire                      speech_busy,
	input  wire  [7:0]               col_select,
	output logic [7:0]               row_data
);

	// Player buttons, joystick bit order
	logic [5:0] p1;
	logic [5:0] p2;
	logic       start1;
	logic       start2;
	logic       coin;
	logic [7:0] col0;
	logic [7:0] col1;
	logic [7:0] col2;

	// Fire then R L D U, inverted
	function automatic logic [4:0] fire_dirs(input logic [5:0] p);
		fire_dirs = {~p[4], ~p[0], ~p[1], ~p[2], ~p[3]};
	endfunction

	// R L D U, inverted
	function automatic logic [3:0] dirs(input logic [5:0] p);
		dirs = {~p[0], ~p[1], ~p[2], ~p[3]};
	endfunction

	//======================================================================
	// Keyboard merged with joysticks
	//======================================================================

	assign p1 = keys[5:0] | joystick_0[5:0];
	assign p2 = keys[17:12] | joystick_1[5:0];

	// Start and coin from player 1 stick only
	assign start1 = keys[6] | keys[9] | joystick_0[6];
	assign start2 = keys[7] | keys[10] | joystick_0[7];
	assign coin   = keys[8] | keys[11] | joystick_0[8];

	//======================================================================
	// Per-game rows for columns 0 to 2
	//======================================================================

	always_comb begin
		case (game)
			astro_pkg::GAME_SPACEZAP: begin
				col0 = {2'b11, ~start2, ~start1, dip2[1], 1'b1, ~coin, 1'b1};
				col1 = {3'b111, fire_dirs(p2)};
				col2 = {2'b11, dip2[0], fire_dirs(p1)};
			end
			astro_pkg::GAME_GORF: begin
				col0 = {dip2[2], dip2[0], ~start2, ~start1, 1'b1, dip2[1], ~coin, 1'b1};
				col1 = {3'b001, fire_dirs(p2)};
				// Top bit reports the speech chip
				col2 = {speech_busy, 2'b01, fire_dirs(p1)};
			end
			astro_pkg::GAME_ROBBY: begin
				col0 = {1'b0, ~start2, ~start1, 1'b1, dip2[1], 1'b1, ~coin, 1'b1};
				col1 = {2'b11, ~p2[4], 1'b1, dirs(p2)};
				col2 = {2'b11, ~p1[4], 1'b1, dirs(p1)};
			end
			astro_pkg::GAME_WOW: begin
				col0 = {dip2[2], ~start2, ~start1, 1'b1, dip2[1], 1'b1, ~coin, 1'b1};
				// Digital stick, fire 2 is active high here
				col1 = {2'b11, ~p2[4], p2[5], dirs(p2)};
				col2 = {speech_busy, 1'b1, ~p1[4], p1[5], dirs(p1)};
			end
			default: begin
				col0 = 8'hFF;
				col1 = 8'hFF;
				col2 = 8'hFF;
			end
		endcase
	end

	// Column strobe decode, DIP bank 3 on column 3 for all games
	always_comb begin
		case (col_select)
			`ASTRO_COL0: row_data = col0;
			`ASTRO_COL1: row_data = col1;
			`ASTRO_COL2: row_data = col2;
			`ASTRO_COL3: row_data = dip3;
			default:     row_data = 8'hFF;
		endcase
	end

endmodule

`default_nettype wire

/* key_decoder.sv */
//==========================================================================
// Keyboard decoder
// Turns make/break scan events into held button bits
//==========================================================================
`default_nettype none
`include "astro_defines.svh"

// Button bits
//  0 R   1 L   2 D   3 U   4 F1   5 F2    player 1
//  6 S1  7 S2  8 coin                   function keys
//  9 S1 10 S2 11 coin                   arcade panel keys
// 12 R  13 L  14 D  15 U  16 F1  17 F2  player 2
module key_decoder (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  wire  [`ASTRO_KEY_W-1:0] ps2_key,
	output logic [17:0]             keys
);

	logic       toggle_q;
	logic       pressed;
	logic [8:0] code;

	assign pressed = ps2_key[9];
	assign code    = ps2_key[8:0];

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			toggle_q <= 1'b0;
			keys     <= '0;
		end else begin
			toggle_q <= ps2_key[10];
			// New event when the toggle flips
			if (toggle_q != ps2_key[10]) begin
				casez (code)
					// Cursor keys, either extended prefix
					9'b?_0111_0101: keys[3]  <= pressed;
					9'b?_0111_0010: keys[2]  <= pressed;
					9'b?_0110_1011: keys[1]  <= pressed;
					9'b?_0111_0100: keys[0]  <= pressed;
					// Ctrl and space
					9'h014:         keys[4]  <= pressed;
					9'h029:         keys[5]  <= pressed;
					// F1 F2 F3
					9'h005:         keys[6]  <= pressed;
					9'h006:         keys[7]  <= pressed;
					9'h004:         keys[8]  <= pressed;
					// 1, 2 and 5 on the panel
					9'h016:         keys[9]  <= pressed;
					9'h01E:         keys[10] <= pressed;
					9'h02E:         keys[11] <= pressed;
					// Player 2 on R F D G
					9'h02D:         keys[15] <= pressed;
					9'h02B:         keys[14] <= pressed;
					9'h023:         keys[13] <= pressed;
					9'h034:         keys[12] <= pressed;
					// A and S fire
					9'h01C:         keys[16] <= pressed;
					9'h01B:         keys[17] <= pressed;
					default:        ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* game_config.sv */
//==========================================================================
// Game configuration
// Host load responder, holds the game select byte and the DIP switch bank
//==========================================================================
`default_nettype none
`include "astro_defines.svh"

module game_config (
	input  wire                           clk_sys,
	input  wire                           reset,
	// Host load, four-phase req/ack
	input  wire                           load_req,
	input  wire  [7:0]                    load_index,
	input  wire  [`ASTRO_LOAD_ADDR_W-1:0] load_addr,
	input  wire  [7:0]                    load_data,
	output logic                          load_ack,
	// Decoded configuration
	output astro_pkg::game_t              game,
	output logic [7:0]                    dip0,
	output logic [7:0]                    dip2,
	output logic [7:0]                    dip3
);

	localparam int DIP_AW = $clog2(`ASTRO_DIP_BYTES);

	// Handshake states
	typedef enum logic {
		ACK_IDLE,
		ACK_HOLD
	} ack_state_t;

	ack_state_t               ack_state;
	astro_pkg::load_target_t  load_target;
	logic                     load_take;
	logic [7:0]               game_raw;
	logic [7:0]               dip_mem [`ASTRO_DIP_BYTES];

	// Raw byte to game, unknown bytes select nothing
	function automatic astro_pkg::game_t decode_game(input logic [7:0] raw);
		case (raw)
			8'd3:    decode_game = astro_pkg::GAME_SPACEZAP;
			8'd4:    decode_game = astro_pkg::GAME_GORF;
			8'd5:    decode_game = astro_pkg::GAME_WOW;
			8'd6:    decode_game = astro_pkg::GAME_ROBBY;
			default: decode_game = astro_pkg::GAME_NONE;
		endcase
	endfunction

	// Classify the pending write
	always_comb begin
		if (load_index == `ASTRO_LOAD_GAME) begin
			load_target = astro_pkg::LOAD_GAME;
		end else if (load_index == `ASTRO_LOAD_DIP &&
				load_addr[`ASTRO_LOAD_ADDR_W-1:DIP_AW] == '0) begin
			load_target = astro_pkg::LOAD_DIP;
		end else begin
			load_target = astro_pkg::LOAD_IGNORE;
		end
	end

	// One write per request, on the req edge seen from idle
	assign load_take = (ack_state == ACK_IDLE) && load_req;
	assign load_ack  = (ack_state == ACK_HOLD);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			ack_state <= ACK_IDLE;
			game_raw  <= 8'd0;
			game      <= astro_pkg::GAME_NONE;
			for (int i = 0; i < `ASTRO_DIP_BYTES; i++) begin
				dip_mem[i] <= 8'd0;
			end
		end else begin
			case (ack_state)
				ACK_IDLE: if (load_req) ack_state <= ACK_HOLD;
				ACK_HOLD: if (!load_req) ack_state <= ACK_IDLE;
				default:  ack_state <= ACK_IDLE;
			endcase
			if (load_take && load_target == astro_pkg::LOAD_GAME) begin
				game_raw <= load_data;
			end
			if (load_take && load_target == astro_pkg::LOAD_DIP) begin
				dip_mem[load_addr[DIP_AW-1:0]] <= load_data;
			end
			// Second stage, decoded game
			game <= decode_game(game_raw);
		end
	end

	// Only these banks reach the switch matrix
	assign dip0 = dip_mem[0];
	assign dip2 = dip_mem[2];
	assign dip3 = dip_mem[3];

endmodule

`default_nettype wire

/* astro_pkg.sv */
//==========================================================================
// Astrocade I/O glue types
// Game identity and host load target enums
//==========================================================================
`default_nettype none

package astro_pkg;

	//======================================================================
	// Game identity
	//======================================================================

	// Encoded with the same value as the host game byte
	typedef enum logic [2:0] {
		GAME_NONE     = 3'd0,
		GAME_SPACEZAP = 3'd3,
		GAME_GORF     = 3'd4,
		GAME_WOW      = 3'd5,
		GAME_ROBBY    = 3'd6
	} game_t;

	//======================================================================
	// Host load classification
	//======================================================================

	// Where a host write lands
	typedef enum logic [1:0] {
		// Acknowledged, no state change
		LOAD_IGNORE,
		// Game select byte
		LOAD_GAME,
		// One of the DIP switch bytes
		LOAD_DIP
	} load_target_t;

endpackage

`default_nettype wire

/* astro_defines.svh */
//==========================================================================
// Astrocade I/O glue shared constants
// Bus widths, host load codes, speech mix shifts and switch column codes
//==========================================================================
`ifndef ASTRO_DEFINES_SVH
`define ASTRO_DEFINES_SVH

// Host load bus
`define ASTRO_LOAD_ADDR_W 16

// Keyboard event: toggle, pressed, 9-bit scan code
`define ASTRO_KEY_W 11

// Joystick: R L D U F1 F2 S1 S2 coin, from bit 0 up
`define ASTRO_JOY_W 9

// DIP switch bank
`define ASTRO_DIP_BYTES 8

// Load index values
`define ASTRO_LOAD_GAME 8'd1
`define ASTRO_LOAD_DIP 8'd254

// Gorf mix, chip sound halved and speech quartered
`define ASTRO_SOUND_SHIFT 1
`define ASTRO_SPEECH_SHIFT 2

// Switch matrix column strobes, one-hot
`define ASTRO_COL0 8'h01
`define ASTRO_COL1 8'h02
`define ASTRO_COL2 8'h04
`define ASTRO_COL3 8'h08

`endif
